// File: build.f
+incdir+verilog
verilog/cache_pkg.sv
verilog/mem_pkg.sv
verilog/mem_req_if.sv
verilog/cache_arrays.sv
verilog/cache_controller.sv
verilog/evict_engine.sv
verilog/fill_engine.sv
verilog/mem_port_arbiter.sv
verilog/dcache_top.sv
verification/dcache_checker.sv
verification/tb_dcache.sv

// File: run.sh
#!/bin/sh
# compile the cache testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_dcache -o sim_dcache
output=$(./obj_dir/sim_dcache)
echo "$output"

if echo "$output" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1

// File: verification/tb_dcache.sv
`timescale 1ns/10ps
`include "dcache_settings.svh"

module tb_dcache;

    localparam int TIMEOUT     = 200;   // cycles allowed per wait
    localparam int HOLD_CYCLES = 40;
    localparam int EXPECT_WB   = 3;     // dirty victims in the table
    localparam int LINES       = 4096;
    localparam int LA_BITS     = `DC_ADDR_BITS - `DC_WSEL_BITS - `DC_BOFF_BITS;
    localparam int LINE_BITS   = `DC_WORD_BITS * `DC_LINE_WORDS;

    localparam logic [1:0] OP_RD   = 2'd0;
    localparam logic [1:0] OP_WR   = 2'd1;
    localparam logic [1:0] OP_WRND = 2'd2;   // store with random data
    localparam logic [1:0] OP_HOLD = 2'd3;   // opens a credit withholding window

    typedef struct packed {
        logic [1:0]               op;
        logic [`DC_ADDR_BITS-1:0] addr;
        logic [`DC_WORD_BITS-1:0] wdata;
        logic [3:0]               mask;
        logic                     hit;   // expected to hit
    } row_t;

    logic                     clock = 1'b0;
    logic                     reset_n;
    logic                     cpu_valid;
    logic                     cpu_ready;
    logic                     cpu_write;
    logic [`DC_ADDR_BITS-1:0] cpu_addr;
    logic [`DC_WORD_BITS-1:0] cpu_wdata;
    logic [3:0]               cpu_wmask;
    logic [`DC_WORD_BITS-1:0] cpu_rdata;
    logic                     cpu_done;
    logic                     mem_req_valid;
    logic                     mem_req_write;
    logic [LA_BITS-1:0]       mem_req_addr;
    logic [LINE_BITS-1:0]     mem_req_line;
    logic                     mem_credit_return;
    logic                     mem_resp_valid;
    logic [LINE_BITS-1:0]     mem_resp_line;
    logic                     expect_hit;
    logic                     finished;
    logic                     timed_out;
    int                       tb_errors;
    int                       error_count;
    int                       writebacks;
    int                       hold_req;
    integer                   seed = 75029;
    row_t                     rows [$];
    logic [LINE_BITS-1:0]     mem_lines [LINES];

    dcache_top DUT (.*);

    dcache_checker u_checker (.*);

    always #50 clock = ~clock;

    function automatic logic [LINE_BITS-1:0] initial_line(input int line_addr);
        logic [LINE_BITS-1:0] line;
        for (int w = 0; w < `DC_LINE_WORDS; w++) begin
            line[w*`DC_WORD_BITS +: `DC_WORD_BITS] = (line_addr * `DC_LINE_WORDS + w) ^ 32'h5A5A0000;
        end
        return line;
    endfunction

    // memory model: reads answer after 2 cycles, credits come back after 3
    initial begin : memory_model
        int                   resp_cnt;
        int                   owed;
        int                   hold_left;
        int                   hold_seen;
        logic [2:0]           req_pipe;
        logic [LINE_BITS-1:0] resp_q;
        mem_credit_return = 1'b0;
        mem_resp_valid    = 1'b0;
        mem_resp_line     = '0;
        resp_cnt  = 0;
        owed      = 0;
        hold_left = 0;
        hold_seen = 0;
        req_pipe  = '0;
        resp_q    = '0;
        for (int a = 0; a < LINES; a++) begin
            mem_lines[a] = initial_line(a);
        end
        forever begin
            @(negedge clock);
            mem_resp_valid    = 1'b0;
            mem_credit_return = 1'b0;
            if (resp_cnt > 0) begin
                resp_cnt--;
                if (resp_cnt == 0) begin
                    mem_resp_valid = 1'b1;
                    mem_resp_line  = resp_q;
                end
            end
            if (req_pipe[2]) begin
                owed++;
            end
            req_pipe = {req_pipe[1:0], mem_req_valid};
            if (hold_req != hold_seen) begin
                hold_seen = hold_req;
                hold_left = HOLD_CYCLES;
            end
            if (hold_left > 0) begin
                hold_left--;   // credits pile up in owed
            end else if (owed > 0) begin
                owed--;
                mem_credit_return = 1'b1;
            end
            if (mem_req_valid) begin
                if (mem_req_write) begin
                    mem_lines[mem_req_addr] = mem_req_line;
                end else begin
                    resp_cnt = 2;
                    resp_q   = mem_lines[mem_req_addr];
                end
            end
        end
    end

    task automatic add_row(input logic [1:0] op, input logic [`DC_ADDR_BITS-1:0] addr,
                           input logic [`DC_WORD_BITS-1:0] wdata, input logic [3:0] mask,
                           input logic hit);
        row_t r;
        r.op    = op;
        r.addr  = addr;
        r.wdata = wdata;
        r.mask  = mask;
        r.hit   = hit;
        rows.push_back(r);
    endtask

    // lines 11xx, 22xx, 33xx, 44xx all map to set 3
    task automatic fill_table();
        add_row(OP_RD,   16'h1134, 32'h0,         4'h0, 1'b0);   // cold miss
        add_row(OP_RD,   16'h1134, 32'h0,         4'h0, 1'b1);
        add_row(OP_WRND, 16'h1138, 32'h0,         4'h6, 1'b1);   // partial write hit
        add_row(OP_RD,   16'h1138, 32'h0,         4'h0, 1'b1);
        add_row(OP_WRND, 16'h2234, 32'h0,         4'h9, 1'b0);   // write miss into way 1
        add_row(OP_RD,   16'h2234, 32'h0,         4'h0, 1'b1);
        add_row(OP_RD,   16'h3330, 32'h0,         4'h0, 1'b0);   // evicts dirty 11xx
        add_row(OP_RD,   16'h1138, 32'h0,         4'h0, 1'b0);   // back from memory, evicts 22xx
        add_row(OP_RD,   16'h2234, 32'h0,         4'h0, 1'b0);
        add_row(OP_WR,   16'h113C, 32'h1234ABCD,  4'hF, 1'b1);
        add_row(OP_HOLD, 16'h0,    32'h0,         4'h0, 1'b0);
        add_row(OP_RD,   16'h3334, 32'h0,         4'h0, 1'b0);   // uses both credits
        add_row(OP_RD,   16'h4430, 32'h0,         4'h0, 1'b0);   // stalls for a credit
        add_row(OP_RD,   16'h113C, 32'h0,         4'h0, 1'b0);
        add_row(OP_RD,   16'h0000, 32'h0,         4'h0, 1'b0);
        add_row(OP_WRND, 16'h5678, 32'h0,         4'h3, 1'b0);
        add_row(OP_RD,   16'h5678, 32'h0,         4'h0, 1'b1);
        add_row(OP_RD,   16'h567C, 32'h0,         4'h0, 1'b1);
    endtask

    task automatic access(input logic write, input logic [`DC_ADDR_BITS-1:0] addr,
                          input logic [`DC_WORD_BITS-1:0] data, input logic [3:0] mask,
                          input logic hit);
        int n;
        @(negedge clock);
        cpu_valid  = 1'b1;
        cpu_write  = write;
        cpu_addr   = addr;
        cpu_wdata  = data;
        cpu_wmask  = mask;
        expect_hit = hit;
        n = 0;
        while (!cpu_ready && n < TIMEOUT) begin
            @(negedge clock);
            n++;
        end
        if (!cpu_ready) begin
            $display("timeout at %0t: cache never took the access to %04h", $time, addr);
            tb_errors++;
            timed_out = 1'b1;
            cpu_valid = 1'b0;
        end else begin
            @(negedge clock);   // taken on the edge just passed
            cpu_valid = 1'b0;
            n = 0;
            while (!cpu_done && n < TIMEOUT) begin
                @(negedge clock);
                n++;
            end
            if (!cpu_done) begin
                $display("timeout at %0t: access to %04h never completed", $time, addr);
                tb_errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic apply_row(input row_t r);
        logic [`DC_WORD_BITS-1:0] data;
        data = r.wdata;
        if (r.op == OP_HOLD) begin
            @(posedge clock);
            hold_req++;
        end else begin
            if (r.op == OP_WRND) begin
                data = $random(seed);
            end
            access(r.op != OP_RD, r.addr, data, r.mask, r.hit);
        end
    endtask

    initial begin
        reset_n    = 1'b0;
        cpu_valid  = 1'b0;
        cpu_write  = 1'b0;
        cpu_addr   = '0;
        cpu_wdata  = '0;
        cpu_wmask  = '0;
        expect_hit = 1'b0;
        finished   = 1'b0;
        timed_out  = 1'b0;
        tb_errors  = 0;
        hold_req   = 0;
        fill_table();
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
        if (!cpu_ready || cpu_done || mem_req_valid) begin
            $display("Fail at %0t: outputs not idle after reset", $time);
            tb_errors++;
        end

        foreach (rows[i]) begin
            if (!timed_out) begin
                apply_row(rows[i]);
            end
        end

        @(negedge clock);
        if (writebacks != EXPECT_WB) begin
            $display("Fail at %0t: saw %0d write-backs, expected %0d", $time, writebacks, EXPECT_WB);
            tb_errors++;
        end
        finished = 1'b1;
        @(negedge clock);
        if (tb_errors == 0 && error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: verification/dcache_checker.sv
`timescale 1ns/10ps
`include "dcache_settings.svh"

module dcache_checker import cache_pkg::*; (
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic                     cpu_valid,
    input  logic                     cpu_ready,
    input  logic                     cpu_write,
    input  logic [`DC_ADDR_BITS-1:0] cpu_addr,
    input  word_t                    cpu_wdata,
    input  byte_mask_t               cpu_wmask,
    input  word_t                    cpu_rdata,
    input  logic                     cpu_done,
    input  logic                     mem_req_valid,
    input  logic                     mem_req_write,
    input  logic [`DC_ADDR_BITS-`DC_WSEL_BITS-`DC_BOFF_BITS-1:0] mem_req_addr,
    input  line_t                    mem_req_line,
    input  logic                     mem_credit_return,
    input  logic                     expect_hit,
    input  int                       tb_errors,
    input  logic                     finished,
    output int                       error_count,
    output int                       writebacks
);

    localparam int WORDS = 1 << (`DC_ADDR_BITS - `DC_BOFF_BITS);

    word_t shadow [WORDS];   // what the load/store side should see
    logic  busy;
    logic  write_q;
    logic  hit_q;
    int    word_q;           // word address of the access in flight
    int    cycles;
    int    outstanding;      // memory requests not yet paid back by a credit
    int    accesses;
    int    addr_base;

    function automatic word_t merge_bytes(input word_t old, input word_t data,
                                          input byte_mask_t mask);
        word_t res;
        res = old;
        for (int b = 0; b < $bits(byte_mask_t); b++) begin
            if (mask[b]) begin
                res[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return res;
    endfunction

    always @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < WORDS; i++) begin
                shadow[i] = word_t'(i) ^ 32'h5A5A0000;   // same rule as the memory model
            end
            busy        = 1'b0;
            write_q     = 1'b0;
            hit_q       = 1'b0;
            word_q      = 0;
            cycles      = 0;
            outstanding = 0;
            accesses    = 0;
            error_count = 0;
            writebacks  = 0;
        end else begin
            if (mem_req_valid && outstanding >= `DC_MEM_CREDITS) begin
                $display("Fail at %0t: memory request sent with %0d credits in use",
                         $time, outstanding);
                error_count++;
            end
            if (mem_req_valid && mem_req_write) begin
                writebacks++;
                addr_base = int'(mem_req_addr) * `DC_LINE_WORDS;
                for (int w = 0; w < `DC_LINE_WORDS; w++) begin
                    if (mem_req_line[w] !== shadow[addr_base + w]) begin
                        $display("Fail at %0t: write-back of line %03h word %0d is %h, expected %h",
                                 $time, mem_req_addr, w, mem_req_line[w], shadow[addr_base + w]);
                        error_count++;
                    end
                end
            end
            outstanding += int'(mem_req_valid) - int'(mem_credit_return);

            if (cpu_done && !busy) begin
                $display("Fail at %0t: cpu_done with no access in flight", $time);
                error_count++;
            end
            if (cpu_rdata !== '0 && !(cpu_done && busy && !write_q)) begin
                $display("Fail at %0t: cpu_rdata is %h outside a read completion", $time, cpu_rdata);
                error_count++;
            end

            if (busy) begin
                cycles++;
                if (cpu_ready) begin
                    $display("Fail at %0t: cpu_ready high before cpu_done", $time);
                    error_count++;
                end
                if (cpu_done) begin
                    busy = 1'b0;
                    if (hit_q && cycles != 2) begin
                        $display("Fail at %0t: hit took %0d cycles, expected 2", $time, cycles);
                        error_count++;
                    end else if (!hit_q && cycles <= 2) begin
                        $display("Fail at %0t: miss took only %0d cycles", $time, cycles);
                        error_count++;
                    end
                    if (!write_q && cpu_rdata !== shadow[word_q]) begin
                        $display("Fail at %0t: read of word %04h returned %h, expected %h",
                                 $time, word_q, cpu_rdata, shadow[word_q]);
                        error_count++;
                    end
                end
            end else if (cpu_valid && cpu_ready) begin
                busy    = 1'b1;
                cycles  = 0;
                write_q = cpu_write;
                hit_q   = expect_hit;
                word_q  = int'(cpu_addr >> `DC_BOFF_BITS);
                accesses++;
                if (cpu_write) begin
                    shadow[word_q] = merge_bytes(shadow[word_q], cpu_wdata, cpu_wmask);
                end
            end
        end
    end

    always @(posedge finished) begin
        $display("checker: %0d accesses, %0d write-backs, %0d check errors, %0d testbench errors",
                 accesses, writebacks, error_count, tb_errors);
    end

endmodule

// File: verilog/dcache_top.sv
`timescale 1ns/10ps

module dcache_top import cache_pkg::*; import mem_pkg::*; (
    input  logic         clock,
    input  logic         reset_n,
    input  logic         cpu_valid,
    output logic         cpu_ready,
    input  logic         cpu_write,
    input  addr_fields_t cpu_addr,
    input  word_t        cpu_wdata,
    input  byte_mask_t   cpu_wmask,
    output word_t        cpu_rdata,
    output logic         cpu_done,
    output logic         mem_req_valid,
    output logic         mem_req_write,
    output line_addr_t   mem_req_addr,
    output mem_line_t    mem_req_line,
    input  logic         mem_credit_return,
    input  logic         mem_resp_valid,
    input  mem_line_t    mem_resp_line
);

    // array ports
    set_index_t    rd_index;
    way_tags_arr_t rd_tags;
    way_lines_t    rd_lines;
    logic          victim_way;
    logic          wr_en;
    set_index_t    wr_index;
    logic          wr_way;
    way_tags_t     wr_tags;
    line_t         wr_line;
    line_mask_t    wr_word_mask;
    logic          fill;

    // engine handshakes
    logic          evict_start;
    line_addr_t    evict_addr;
    line_t         evict_line;
    logic          evict_done;
    logic          fill_start;
    line_addr_t    fill_addr;
    word_t         fill_word;
    byte_mask_t    fill_mask;
    word_sel_t     fill_sel;
    logic          fill_write;
    logic          fill_done;
    line_t         fill_line;

    mem_req_if evict_ch ();
    mem_req_if fill_ch ();

    cache_arrays u_arrays (.*);

    cache_controller u_controller (.*);

    evict_engine u_evict (.*, .req(evict_ch));

    fill_engine u_fill (.*, .req(fill_ch));

    mem_port_arbiter u_arbiter (
        .*,
        .evict_req(evict_ch),
        .fill_req (fill_ch)
    );

endmodule

// File: verilog/mem_port_arbiter.sv
`timescale 1ns/10ps

module mem_port_arbiter import mem_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    mem_req_if.receiver evict_req,
    mem_req_if.receiver fill_req,
    output logic        mem_req_valid,
    output logic        mem_req_write,
    output line_addr_t  mem_req_addr,
    output mem_line_t   mem_req_line,
    input  logic        mem_credit_return
);

    credit_t  credits;
    logic     have_credit;
    mem_req_t sel_req;

    assign have_credit = (credits != '0);

    // write-back wins so memory sees the old line before its refill
    assign evict_req.granted = evict_req.req_valid && have_credit;
    assign fill_req.granted  = fill_req.req_valid && !evict_req.req_valid && have_credit;

    assign sel_req       = evict_req.req_valid ? evict_req.req : fill_req.req;
    assign mem_req_valid = evict_req.granted || fill_req.granted;
    assign mem_req_write = sel_req.write;
    assign mem_req_addr  = sel_req.addr;
    assign mem_req_line  = sel_req.line;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            credits <= credit_t'(MEM_CREDITS);
        end else begin
            credits <= credits - credit_t'(mem_req_valid) + credit_t'(mem_credit_return);
        end
    end

    assert property (@(posedge clock) disable iff (!reset_n) credits <= credit_t'(MEM_CREDITS))
        else $error("mem_port_arbiter: more credits returned than issued");

    // a waiting engine keeps its request up and steady until the grant
    assert property (@(posedge clock) disable iff (!reset_n)
        (evict_req.req_valid && !evict_req.granted) |=>
            (evict_req.req_valid && $stable(evict_req.req)))
        else $error("mem_port_arbiter: write-back request changed before its grant");

    assert property (@(posedge clock) disable iff (!reset_n)
        (fill_req.req_valid && !fill_req.granted) |=>
            (fill_req.req_valid && $stable(fill_req.req)))
        else $error("mem_port_arbiter: line read request changed before its grant");

endmodule

// File: verilog/fill_engine.sv
`timescale 1ns/10ps

module fill_engine import cache_pkg::*; import mem_pkg::*; (
    input  logic       clock,
    input  logic       reset_n,
    input  logic       fill_start,
    input  line_addr_t fill_addr,
    input  word_t      fill_word,
    input  byte_mask_t fill_mask,
    input  word_sel_t  fill_sel,
    input  logic       fill_write,
    output logic       fill_done,
    output line_t      fill_line,
    mem_req_if.sender  req,
    input  logic       mem_resp_valid,
    input  mem_line_t  mem_resp_line
);

    logic       req_q;
    logic       wait_q;   // read granted, response not yet seen
    logic       done_q;
    line_addr_t addr_q;
    word_t      word_q;
    byte_mask_t mask_q;
    word_sel_t  sel_q;
    logic       write_q;
    line_t      merged;
    line_t      line_q;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            req_q  <= 1'b0;
            wait_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            if (fill_start) begin
                req_q <= 1'b1;
            end else if (req.granted) begin
                req_q <= 1'b0;
            end
            if (req.granted) begin
                wait_q <= 1'b1;
            end else if (mem_resp_valid) begin
                wait_q <= 1'b0;
            end
            done_q <= mem_resp_valid && wait_q;
        end
    end

    // pending store lands over the returned line
    always_comb begin
        merged = mem_resp_line;
        if (write_q) begin
            for (int b = 0; b < $bits(byte_mask_t); b++) begin
                if (mask_q[b]) begin
                    merged[sel_q][b*8 +: 8] = word_q[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fill_start) begin
            addr_q  <= fill_addr;
            word_q  <= fill_word;
            mask_q  <= fill_mask;
            sel_q   <= fill_sel;
            write_q <= fill_write;
        end
        if (mem_resp_valid) begin
            line_q <= merged;
        end
    end

    assign req.req_valid  = req_q;
    assign req.req.write  = 1'b0;
    assign req.req.addr   = addr_q;
    assign req.req.line   = '0;
    assign fill_done      = done_q;
    assign fill_line      = line_q;   // held until the next fill

    assert property (@(posedge clock) disable iff (!reset_n) mem_resp_valid |-> wait_q)
        else $error("fill_engine: memory response with no fill outstanding");

endmodule

// File: verilog/evict_engine.sv
`timescale 1ns/10ps

module evict_engine import cache_pkg::*; import mem_pkg::*; (
    input  logic       clock,
    input  logic       reset_n,
    input  logic       evict_start,
    input  line_addr_t evict_addr,
    input  line_t      evict_line,
    output logic       evict_done,
    mem_req_if.sender  req
);

    logic     pending_q;
    mem_req_t wb_q;   // copy of the victim, array may be rewritten meanwhile

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pending_q <= 1'b0;
        end else if (evict_start) begin
            pending_q <= 1'b1;
        end else if (req.granted) begin
            pending_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (evict_start) begin
            wb_q.write <= 1'b1;
            wb_q.addr  <= evict_addr;
            wb_q.line  <= evict_line;
        end
    end

    assign req.req_valid = pending_q;
    assign req.req       = wb_q;
    assign evict_done    = req.granted;

endmodule

// File: verilog/cache_controller.sv
`timescale 1ns/10ps

module cache_controller import cache_pkg::*; import mem_pkg::*; (
    input  logic          clock,
    input  logic          reset_n,
    input  logic          cpu_valid,
    output logic          cpu_ready,
    input  logic          cpu_write,
    input  addr_fields_t  cpu_addr,
    input  word_t         cpu_wdata,
    input  byte_mask_t    cpu_wmask,
    output word_t         cpu_rdata,
    output logic          cpu_done,
    output set_index_t    rd_index,
    input  way_tags_arr_t rd_tags,
    input  way_lines_t    rd_lines,
    input  logic          victim_way,
    output logic          wr_en,
    output set_index_t    wr_index,
    output logic          wr_way,
    output way_tags_t     wr_tags,
    output line_t         wr_line,
    output line_mask_t    wr_word_mask,
    output logic          fill,
    output logic          evict_start,
    output line_addr_t    evict_addr,
    output line_t         evict_line,
    input  logic          evict_done,
    output logic          fill_start,
    output line_addr_t    fill_addr,
    output word_t         fill_word,
    output byte_mask_t    fill_mask,
    output word_sel_t     fill_sel,
    output logic          fill_write,
    input  logic          fill_done,
    input  line_t         fill_line
);

    cache_state_t state;
    cache_state_t next_state;
    addr_fields_t addr_q;
    logic         write_q;
    word_t        wdata_q;
    byte_mask_t   wmask_q;
    word_t        rdata_q;
    logic         victim_q;
    way_vec_t     hit;
    logic         any_hit;
    logic         hit_way;
    way_tags_t    vic_tags;
    logic         in_lookup;

    assign in_lookup = (state == LOOKUP);
    assign rd_index  = cpu_addr.index;   // array read launches on the accepting edge

    always_comb begin
        for (int w = 0; w < $bits(way_vec_t); w++) begin
            hit[w] = rd_tags[w].valid && (rd_tags[w].tag == addr_q.tag);
        end
    end

    assign any_hit  = |hit;
    assign hit_way  = hit[1];
    assign vic_tags = rd_tags[victim_way];

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (cpu_valid) next_state = LOOKUP;
            LOOKUP: begin
                if (any_hit)          next_state = RESPOND;
                else if (evict_start) next_state = EVICT;
                else                  next_state = FILL;
            end
            EVICT:   if (evict_done) next_state = FILL;   // write-back granted
            FILL:    if (fill_done) next_state = UPDATE;
            UPDATE:  next_state = RESPOND;
            RESPOND: next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clock) begin
        if (cpu_valid && cpu_ready) begin
            addr_q  <= cpu_addr;
            write_q <= cpu_write;
            wdata_q <= cpu_wdata;
            wmask_q <= cpu_wmask;
        end
        if (in_lookup) begin
            victim_q <= victim_way;
            rdata_q  <= rd_lines[hit_way][addr_q.word];
        end else if (state == UPDATE) begin
            rdata_q <= fill_line[addr_q.word];   // refilled word, store already merged
        end
    end

    assign cpu_ready = (state == IDLE);
    assign cpu_done  = (state == RESPOND);
    assign cpu_rdata = (cpu_done && !write_q) ? rdata_q : '0;

    // miss: fill always, write-back too when the victim is dirty
    assign fill_start  = in_lookup && !any_hit;
    assign evict_start = fill_start && vic_tags.valid && vic_tags.dirty;
    assign evict_addr  = {vic_tags.tag, addr_q.index};
    assign evict_line  = rd_lines[victim_way];
    assign fill_addr   = {addr_q.tag, addr_q.index};
    assign fill_word   = wdata_q;
    assign fill_mask   = wmask_q;
    assign fill_sel    = addr_q.word;
    assign fill_write  = write_q;

    assign wr_index = addr_q.index;

    always_comb begin
        wr_en        = 1'b0;
        wr_way       = hit_way;
        wr_tags      = '{valid: 1'b1, dirty: 1'b1, tag: addr_q.tag};
        wr_line      = '0;
        wr_word_mask = '0;
        fill         = 1'b0;
        if (in_lookup && any_hit && write_q) begin
            wr_en                     = 1'b1;
            wr_line[addr_q.word]      = wdata_q;
            wr_word_mask[addr_q.word] = wmask_q;
        end else if (state == UPDATE) begin
            wr_en         = 1'b1;
            wr_way        = victim_q;
            wr_tags.dirty = write_q;   // store miss leaves the new line dirty
            wr_line       = fill_line;
            wr_word_mask  = '1;
            fill          = 1'b1;
        end
    end

    assert property (@(posedge clock) disable iff (!reset_n) in_lookup |-> $onehot0(hit))
        else $error("cache_controller: address hits in both ways");

endmodule

// File: verilog/cache_arrays.sv
`timescale 1ns/10ps
`include "dcache_settings.svh"

module cache_arrays import cache_pkg::*; (
    input  logic          clock,
    input  logic          reset_n,
    input  set_index_t    rd_index,
    output way_tags_arr_t rd_tags,
    output way_lines_t    rd_lines,
    output logic          victim_way,
    input  logic          wr_en,
    input  set_index_t    wr_index,
    input  logic          wr_way,
    input  way_tags_t     wr_tags,
    input  line_t         wr_line,
    input  line_mask_t    wr_word_mask,
    input  logic          fill
);

    logic [`DC_SETS-1:0] valid_q [`DC_WAYS];
    logic [`DC_SETS-1:0] dirty_q [`DC_WAYS];
    logic [`DC_SETS-1:0] toggle_q;             // replacement choice when both ways valid
    tag_t                tag_mem [`DC_WAYS][`DC_SETS];
    line_t               line_mem [`DC_WAYS][`DC_SETS];
    logic                rd_toggle;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
            toggle_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_way][wr_index] <= wr_tags.valid;
            dirty_q[wr_way][wr_index] <= wr_tags.dirty;
            if (fill) begin
                toggle_q[wr_index] <= ~toggle_q[wr_index];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en) begin
            tag_mem[wr_way][wr_index] <= wr_tags.tag;
            for (int i = 0; i < `DC_LINE_WORDS; i++) begin
                for (int b = 0; b < `DC_WORD_BITS / 8; b++) begin
                    if (wr_word_mask[i][b]) begin
                        line_mem[wr_way][wr_index][i][b*8 +: 8] <= wr_line[i][b*8 +: 8];
                    end
                end
            end
        end
        // registered read of both ways
        for (int w = 0; w < `DC_WAYS; w++) begin
            rd_tags[w].valid <= valid_q[w][rd_index];
            rd_tags[w].dirty <= dirty_q[w][rd_index];
            rd_tags[w].tag   <= tag_mem[w][rd_index];
            rd_lines[w]      <= line_mem[w][rd_index];
        end
        rd_toggle <= toggle_q[rd_index];
    end

    // an invalid way is always taken first
    assign victim_way = !rd_tags[0].valid ? 1'b0 :
                        !rd_tags[1].valid ? 1'b1 : rd_toggle;

    assert property (@(posedge clock) disable iff (!reset_n)
        wr_en |-> (!$isunknown(wr_index) && (int'(wr_index) < `DC_SETS)))
        else $error("cache_arrays: write to unknown or out of range set %0d", wr_index);

endmodule

// File: verilog/mem_req_if.sv
`timescale 1ns/10ps

interface mem_req_if import mem_pkg::*; ();

    logic     req_valid;   // held until granted
    mem_req_t req;
    logic     granted;     // single cycle pulse

    modport sender (
        output req_valid,
        output req,
        input  granted
    );

    modport receiver (
        input  req_valid,
        input  req,
        output granted
    );

endinterface

// File: verilog/mem_pkg.sv
`include "dcache_settings.svh"

package mem_pkg;

    localparam int MEM_CREDITS = `DC_MEM_CREDITS;

    typedef cache_pkg::line_t mem_line_t;   // memory moves whole cache lines

    // byte address with the line offset dropped
    typedef logic [`DC_ADDR_BITS-`DC_WSEL_BITS-`DC_BOFF_BITS-1:0] line_addr_t;

    typedef logic [$clog2(`DC_MEM_CREDITS+1)-1:0] credit_t;

    typedef struct packed {
        logic       write;   // 1 = write-back, 0 = line read
        line_addr_t addr;
        mem_line_t  line;
    } mem_req_t;

endpackage

// File: verilog/cache_pkg.sv
`include "dcache_settings.svh"

package cache_pkg;

    typedef logic [`DC_WORD_BITS-1:0]     word_t;
    typedef logic [`DC_WORD_BITS/8-1:0]   byte_mask_t;
    typedef logic [`DC_INDEX_BITS-1:0]    set_index_t;
    typedef logic [`DC_TAG_BITS-1:0]      tag_t;
    typedef logic [`DC_WSEL_BITS-1:0]     word_sel_t;
    typedef word_t [`DC_LINE_WORDS-1:0]   line_t;
    typedef byte_mask_t [`DC_LINE_WORDS-1:0] line_mask_t;   // byte enables per word
    typedef logic [`DC_WAYS-1:0]          way_vec_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } way_tags_t;

    typedef way_tags_t [`DC_WAYS-1:0] way_tags_arr_t;
    typedef line_t [`DC_WAYS-1:0]     way_lines_t;

    // load/store address split into cache fields
    typedef struct packed {
        tag_t                     tag;
        set_index_t               index;
        word_sel_t                word;
        logic [`DC_BOFF_BITS-1:0] offset;
    } addr_fields_t;

    typedef enum logic [2:0] {IDLE, LOOKUP, RESPOND, EVICT, FILL, UPDATE} cache_state_t;

endpackage

// File: verilog/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// byte address and data word widths
`define DC_ADDR_BITS   16
`define DC_WORD_BITS   32

// cache geometry
`define DC_LINE_WORDS  4
`define DC_SETS        16
`define DC_WAYS        2

`define DC_MEM_CREDITS 2   // credits held by the memory port after reset

// derived field widths
`define DC_BOFF_BITS   $clog2(`DC_WORD_BITS / 8)
`define DC_WSEL_BITS   $clog2(`DC_LINE_WORDS)
`define DC_INDEX_BITS  $clog2(`DC_SETS)
`define DC_TAG_BITS    (`DC_ADDR_BITS - `DC_INDEX_BITS - `DC_WSEL_BITS - `DC_BOFF_BITS)

`endif
